// File: Bender.yml
package:
  name: uart

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/uart_pkg.sv
      - rtl/uart_rx_if.sv
      - rtl/uart_fifo.sv
      - rtl/uart_baud_gen.sv
      - rtl/uart_rx.sv
      - rtl/uart_tx.sv
      - rtl/uart_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/uart_sva.sv
      - tests/uart_tb.sv

// File: rtl/uart_baud_gen.sv
`timescale 1ns/1ps

module uart_baud_gen (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  uart_pkg::div_t   baud_div_i,
  output logic             tick_o
);

  uart_pkg::div_t cnt_q;
  uart_pkg::div_t div_q;  // divider in use for the current period.

  // the divider is sampled at each wrap so a change never cuts a period short.
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      div_q  <= '0;
      tick_o <= 1'b0;
    end else begin
      tick_o <= 1'b0;
      if (div_q == '0) begin
        // stopped, so keep watching for a usable divider.
        cnt_q <= '0;
        div_q <= baud_div_i;
      end else if (cnt_q == div_q - 1'b1) begin
        cnt_q  <= '0;
        div_q  <= baud_div_i;
        tick_o <= 1'b1;  // one clock wide.
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: rtl/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// frame and buffer sizes shared by the whole UART.

// data bits carried by one frame.
`define UART_DATA_W 8

// entries in each FIFO, a power of two.
`define UART_FIFO_DEPTH 8

// baud ticks per bit period.
`define UART_OVERSAMPLE 16

`define UART_DIV_W 16  // width of the programmable baud divider.

`endif

// File: rtl/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic [WIDTH-1:0] in_data_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [WIDTH-1:0] out_data_o
);

  localparam int unsigned AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [AW-1:0]    wr_ptr_q;
  logic [AW-1:0]    rd_ptr_q;
  logic [AW-1:0]    rd_sel;    // entry that becomes the head next cycle.
  logic [AW:0]      count_q;   // entries held in memory, head included.
  logic [AW:0]      avail;
  logic             push;
  logic             pop;

  assign in_ready_o = (count_q != (AW+1)'(DEPTH));
  assign push       = in_valid_i && in_ready_o;
  assign pop        = out_valid_o && out_ready_i;

  // the head register reloads every cycle from the entry after a pop.
  assign rd_sel = pop ? rd_ptr_q + 1'b1 : rd_ptr_q;
  assign avail  = count_q - (AW+1)'(pop);  // entries already written, minus the one leaving.

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
    out_data_o <= mem_q[rd_sel];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      out_valid_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at DEPTH.
      end
      rd_ptr_q    <= rd_sel;
      count_q     <= count_q + (AW+1)'(push) - (AW+1)'(pop);
      out_valid_o <= (avail != '0);
    end
  end

endmodule

// File: rtl/uart_pkg.sv
`include "uart_defines.svh"

package uart_pkg;

  typedef logic [`UART_DATA_W-1:0] data_t;      // one data byte.
  typedef logic [`UART_DATA_W:0]   rx_entry_t;  // frame error above the data byte.
  typedef logic [`UART_DIV_W-1:0]  div_t;       // clock cycles per baud tick.

  typedef logic [$clog2(`UART_DATA_W)-1:0]     bit_cnt_t;
  typedef logic [$clog2(`UART_OVERSAMPLE)-1:0] tick_cnt_t;

  // receiver FSM.
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // transmitter FSM.
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

endpackage

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            tick_i,
  input  logic            rx_i,
  output uart_pkg::data_t rx_data_o,
  output logic            rx_frame_err_o,
  output logic            rx_valid_o,
  input  logic            rx_ready_i,
  output logic            rx_overrun_o
);

  localparam uart_pkg::tick_cnt_t mid_tick  = uart_pkg::tick_cnt_t'(`UART_OVERSAMPLE / 2 - 1);
  localparam uart_pkg::tick_cnt_t last_tick = uart_pkg::tick_cnt_t'(`UART_OVERSAMPLE - 1);
  localparam uart_pkg::bit_cnt_t  last_bit  = uart_pkg::bit_cnt_t'(`UART_DATA_W - 1);

  logic                rx_meta_q;
  logic                rx_sync_q;
  logic                rx_prev_q;
  logic                rx_fall;
  uart_pkg::rx_state_e state_q;
  uart_pkg::tick_cnt_t tick_cnt_q;
  uart_pkg::bit_cnt_t  bit_cnt_q;
  uart_pkg::data_t     shift_q;
  uart_pkg::rx_entry_t head;

  uart_rx_if rx_wr ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // line synchronizer and start edge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rx_meta_q <= 1'b1;  // the idle line is high.
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  assign rx_fall = rx_prev_q && !rx_sync_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame FSM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= uart_pkg::RX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else begin
      case (state_q)
        uart_pkg::RX_IDLE: begin
          if (rx_fall) begin
            state_q    <= uart_pkg::RX_START;
            tick_cnt_q <= '0;
          end
        end
        uart_pkg::RX_START: begin
          if (tick_i) begin
            if (tick_cnt_q == mid_tick) begin
              // a line that is high again at mid start bit was a glitch.
              state_q    <= rx_sync_q ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
              tick_cnt_q <= '0;
              bit_cnt_q  <= '0;
            end else begin
              tick_cnt_q <= tick_cnt_q + 1'b1;
            end
          end
        end
        uart_pkg::RX_DATA: begin
          if (tick_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;  // wraps to 0 at each sample.
            if (tick_cnt_q == last_tick) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == last_bit) begin
                state_q <= uart_pkg::RX_STOP;
              end
            end
          end
        end
        uart_pkg::RX_STOP: begin
          if (tick_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
            if (tick_cnt_q == last_tick) begin
              state_q <= uart_pkg::RX_IDLE;
            end
          end
        end
        default: state_q <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // data arrives LSB first, so each sample enters at the top.
  always_ff @(posedge clk_i) begin
    if (tick_i && state_q == uart_pkg::RX_DATA && tick_cnt_q == last_tick) begin
      shift_q <= {rx_sync_q, shift_q[`UART_DATA_W-1:1]};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write into the receive FIFO.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rx_wr.valid     = tick_i && (state_q == uart_pkg::RX_STOP) && (tick_cnt_q == last_tick);
  assign rx_wr.data      = shift_q;
  assign rx_wr.frame_err = !rx_sync_q;  // the stop bit must be high.

  // a byte offered to a full FIFO is gone, and the flag stays until reset.
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rx_overrun_o <= 1'b0;
    end else if (rx_wr.valid && !rx_wr.ready) begin
      rx_overrun_o <= 1'b1;
    end
  end

  uart_fifo #(
    .WIDTH($bits(uart_pkg::rx_entry_t)),
    .DEPTH(`UART_FIFO_DEPTH)
  ) i_rx_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (rx_wr.valid),
    .in_ready_o (rx_wr.ready),
    .in_data_i  ({rx_wr.frame_err, rx_wr.data}),
    .out_valid_o(rx_valid_o),
    .out_ready_i(rx_ready_i),
    .out_data_o (head)
  );

  assign rx_frame_err_o = head[`UART_DATA_W];
  assign rx_data_o      = head[`UART_DATA_W-1:0];

endmodule

// File: rtl/uart_rx_if.sv
`timescale 1ns/1ps

// write port from the receiver into its FIFO.
interface uart_rx_if;

  logic            valid;      // one-cycle pulse at the end of a frame.
  logic            ready;      // low when the FIFO is full.
  uart_pkg::data_t data;
  logic            frame_err;  // stop bit was sampled low.

  // the receiver side.
  modport src (output valid, output data, output frame_err, input ready);

  // the FIFO side.
  modport dst (input valid, input data, input frame_err, output ready);

endinterface

// File: rtl/uart_top.sv
`timescale 1ns/1ps

module uart_top (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  uart_pkg::div_t  baud_div_i,
  // transmit side.
  input  uart_pkg::data_t tx_data_i,
  input  logic            tx_valid_i,
  output logic            tx_ready_o,
  output logic            tx_o,
  // receive side.
  input  logic            rx_i,
  output uart_pkg::data_t rx_data_o,
  output logic            rx_frame_err_o,
  output logic            rx_valid_o,
  input  logic            rx_ready_i,
  output logic            rx_overrun_o
);

  logic tick;  // one oversampling tick shared by both directions.

  uart_baud_gen i_baud_gen (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .baud_div_i(baud_div_i),
    .tick_o    (tick)
  );

  uart_tx i_tx (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .tick_i    (tick),
    .tx_data_i (tx_data_i),
    .tx_valid_i(tx_valid_i),
    .tx_ready_o(tx_ready_o),
    .tx_o      (tx_o)
  );

  // the receiver holds its own FIFO.
  uart_rx i_rx (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tick_i        (tick),
    .rx_i          (rx_i),
    .rx_data_o     (rx_data_o),
    .rx_frame_err_o(rx_frame_err_o),
    .rx_valid_o    (rx_valid_o),
    .rx_ready_i    (rx_ready_i),
    .rx_overrun_o  (rx_overrun_o)
  );

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tx (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            tick_i,
  input  uart_pkg::data_t tx_data_i,
  input  logic            tx_valid_i,
  output logic            tx_ready_o,
  output logic            tx_o
);

  localparam uart_pkg::tick_cnt_t last_tick = uart_pkg::tick_cnt_t'(`UART_OVERSAMPLE - 1);
  localparam uart_pkg::bit_cnt_t  last_bit  = uart_pkg::bit_cnt_t'(`UART_DATA_W - 1);

  logic                fifo_valid;
  logic                fifo_ready;
  uart_pkg::data_t     fifo_data;
  uart_pkg::tx_state_e state_q;
  uart_pkg::tick_cnt_t tick_cnt_q;
  uart_pkg::bit_cnt_t  bit_cnt_q;
  uart_pkg::data_t     shift_q;
  logic                bit_val;  // level of the bit that the FSM is in.

  uart_fifo #(
    .WIDTH($bits(uart_pkg::data_t)),
    .DEPTH(`UART_FIFO_DEPTH)
  ) i_tx_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (tx_valid_i),
    .in_ready_o (tx_ready_o),
    .in_data_i  (tx_data_i),
    .out_valid_o(fifo_valid),
    .out_ready_i(fifo_ready),
    .out_data_o (fifo_data)
  );

  assign fifo_ready = (state_q == uart_pkg::TX_IDLE);  // pop only between frames.

  always_comb begin
    case (state_q)
      uart_pkg::TX_START: bit_val = 1'b0;
      uart_pkg::TX_DATA:  bit_val = shift_q[0];
      default:            bit_val = 1'b1;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame FSM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // every bit starts on the tick where the counter is 0 and ends 16 ticks later.
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= uart_pkg::TX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_o       <= 1'b1;
    end else if (state_q == uart_pkg::TX_IDLE) begin
      if (fifo_valid) begin
        state_q    <= uart_pkg::TX_START;
        tick_cnt_q <= '0;
        bit_cnt_q  <= '0;
      end
    end else if (tick_i) begin
      tick_cnt_q <= tick_cnt_q + 1'b1;
      if (tick_cnt_q == '0) begin
        tx_o <= bit_val;
      end
      if (tick_cnt_q == last_tick) begin
        case (state_q)
          uart_pkg::TX_START: state_q <= uart_pkg::TX_DATA;
          uart_pkg::TX_DATA: begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == last_bit) begin
              state_q <= uart_pkg::TX_STOP;
            end
          end
          default: state_q <= uart_pkg::TX_IDLE;  // stop bit done.
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_valid && fifo_ready) begin
      shift_q <= fifo_data;
    end else if (tick_i && state_q == uart_pkg::TX_DATA && tick_cnt_q == last_tick) begin
      shift_q <= shift_q >> 1;  // next bit moves to the bottom.
    end
  end

endmodule

// File: tests/uart_sva.sv
`timescale 1ns/1ps

module uart_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input uart_pkg::tx_state_e tx_state_i,
  input logic                tx_o,
  input logic                rx_valid_o,
  input logic                rx_ready_i,
  input uart_pkg::data_t     rx_data_o,
  input logic                rx_frame_err_o,
  input logic                rx_overrun_o
);

  // the line rests high between frames.
  tx_idle_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_state_i == uart_pkg::TX_IDLE |-> tx_o)
    else $error("tx_o low while the transmitter is idle");

  // a stalled head entry must not change.
  rx_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_valid_o && !rx_ready_i |=> rx_valid_o && $stable(rx_data_o) && $stable(rx_frame_err_o))
    else $error("rx output changed while stalled");

  rx_overrun_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_overrun_o |=> rx_overrun_o)
    else $error("rx_overrun_o fell without a reset");

endmodule

bind uart_top uart_sva i_uart_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .tx_state_i    (i_tx.state_q),
  .tx_o          (tx_o),
  .rx_valid_o    (rx_valid_o),
  .rx_ready_i    (rx_ready_i),
  .rx_data_o     (rx_data_o),
  .rx_frame_err_o(rx_frame_err_o),
  .rx_overrun_o  (rx_overrun_o)
);

// File: tests/uart_tb.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tb;

  localparam int BIT_CYC = 4 * `UART_OVERSAMPLE;  // divider 4 gives 64 cycles per bit.

  logic clk_i;
  logic rst_ni;
  uart_pkg::div_t  baud_div;
  uart_pkg::data_t tx_data;
  logic tx_valid, tx_ready, tx_line, rx_line, rx_ready, rx_valid, rx_err, rx_overrun;
  uart_pkg::data_t rx_data;
  logic bb_q;      // bit-banged line.
  logic loop_en;   // routes tx_o back into rx_i.

  byte cmd_q[$];
  int  arg_a_q[$];
  int  arg_b_q[$];
  uart_pkg::data_t     tx_exp_q[$];  // bytes still owed on tx_o.
  uart_pkg::rx_entry_t rx_got_q[$];  // entries popped from the receiver.
  int  cycles = 0;
  int  limit  = 0;
  int  errors = 0;

  assign rx_line = (loop_en ? tx_line : 1'b1) & bb_q;

  uart_top DUT (
    .clk_i(clk_i), .rst_ni(rst_ni), .baud_div_i(baud_div),
    .tx_data_i(tx_data), .tx_valid_i(tx_valid), .tx_ready_o(tx_ready), .tx_o(tx_line),
    .rx_i(rx_line), .rx_data_o(rx_data), .rx_frame_err_o(rx_err),
    .rx_valid_o(rx_valid), .rx_ready_i(rx_ready), .rx_overrun_o(rx_overrun)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // error reporting and watchdog.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic report_mismatch(input string name, input int exp, input int got);
    errors++;
    $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("%s at time %0t", msg, $time);
    $display("Errors found");
    $fatal(1);
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      report_problem("The run took too long and was stopped");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // receive collector and serial monitor.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk_i) begin
    if (rst_ni && rx_valid && rx_ready) rx_got_q.push_back({rx_err, rx_data});
  end

  // samples tx_o at mid-bit, starting from the first low sample.
  initial begin : tx_monitor
    uart_pkg::data_t b;
    uart_pkg::data_t exp;
    forever begin
      @(posedge clk_i);
      if (rst_ni && tx_line == 1'b0) begin
        repeat (BIT_CYC / 2) @(posedge clk_i);
        for (int i = 0; i < `UART_DATA_W; i++) begin
          repeat (BIT_CYC) @(posedge clk_i);
          b[i] = tx_line;
        end
        repeat (BIT_CYC) @(posedge clk_i);
        assert (tx_line == 1'b1) else report_mismatch("tx_o stop bit", 1, tx_line);
        assert (tx_exp_q.size() > 0) else report_problem("Unexpected byte seen on tx_o");
        exp = tx_exp_q.pop_front();
        assert (b == exp) else report_mismatch("tx_o byte", exp, b);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // drivers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_tx(input uart_pkg::data_t b, inout bit stalled);
    tx_data  = b;
    tx_valid = 1'b1;
    tx_exp_q.push_back(b);
    do begin
      @(posedge clk_i);
      if (!tx_ready) stalled = 1'b1;
    end while (!tx_ready);
    #1;
  endtask

  task automatic bit_bang(input uart_pkg::data_t b, input logic stop);
    logic [9:0] frame;
    frame = {stop, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      bb_q = frame[i];
      repeat (BIT_CYC) @(posedge clk_i);
      #1;
    end
    bb_q = 1'b1;
    repeat (2 + $urandom % 16) @(posedge clk_i);  // random idle gap.
    #1;
  endtask

  task automatic wait_tx_done();
    while (tx_exp_q.size() != 0) @(posedge clk_i);
    repeat (BIT_CYC) @(posedge clk_i);
    #1;
    loop_en = 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : main
    int fd;
    int frames;
    string line;
    byte c;
    int a;
    int b;
    bit stalled;
    uart_pkg::rx_entry_t got;
    void'($urandom(41995));
    rst_ni = 1'b0;
    baud_div = 16'd4;
    tx_data = '0;
    tx_valid = 1'b0;
    rx_ready = 1'b1;
    bb_q = 1'b1;
    loop_en = 1'b0;
    frames = 0;
    fd = $fopen("tests/uart_trace.txt", "r");
    assert (fd != 0) else report_problem("Could not open the trace file");
    while ($fgets(line, fd)) begin
      if (line.len() > 1 && line[0] != "#") begin
        a = 0;
        b = 0;
        void'($sscanf(line, "%c %h %h", c, a, b));
        cmd_q.push_back(c);
        arg_a_q.push_back(a);
        arg_b_q.push_back(b);
        if (c == "L" || c == "B" || c == "G") frames += 1;
        if (c == "H" || c == "T") frames += a;
      end
    end
    $fclose(fd);
    limit = frames * 12 * BIT_CYC + 1000;
    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(posedge clk_i);
    assert (tx_line == 1'b1) else report_mismatch("tx_o", 1, tx_line);
    assert (tx_ready == 1'b1) else report_mismatch("tx_ready_o", 1, tx_ready);
    assert (rx_valid == 1'b0) else report_mismatch("rx_valid_o", 0, rx_valid);
    assert (rx_overrun == 1'b0) else report_mismatch("rx_overrun_o", 0, rx_overrun);
    #1;
    for (int i = 0; i < cmd_q.size(); i++) begin
      a = arg_a_q[i];
      b = arg_b_q[i];
      case (cmd_q[i])
        "L": begin
          loop_en = 1'b1;
          stalled = 1'b0;
          send_tx(a[7:0], stalled);
          tx_valid = 1'b0;
        end
        "T": begin
          wait_tx_done();
          stalled = 1'b0;
          for (int k = 0; k < a; k++) send_tx(8'hc0 + k[7:0], stalled);
          tx_valid = 1'b0;
          assert (stalled) else report_problem("tx_ready_o never fell with the FIFO full");
          wait_tx_done();
        end
        "B": begin
          wait_tx_done();
          bit_bang(a[7:0], b[0]);
        end
        "H": begin
          wait_tx_done();
          rx_ready = 1'b0;
          for (int k = 0; k < a; k++) bit_bang(8'h10 + k[7:0], 1'b1);
          repeat (8) @(posedge clk_i);
          #1 rx_ready = 1'b1;
        end
        "G": begin
          wait_tx_done();
          bb_q = 1'b0;  // shorter than half a bit.
          repeat (a * 4) @(posedge clk_i);
          #1 bb_q = 1'b1;
          // a frame wrongly started by the pulse would have ended by now.
          repeat (11 * BIT_CYC) @(posedge clk_i);
          assert (rx_got_q.size() == 0) else report_problem("A glitch produced a byte");
          assert (rx_valid == 1'b0) else report_mismatch("rx_valid_o", 0, rx_valid);
          #1;
        end
        "E": begin
          while (rx_got_q.size() == 0) @(posedge clk_i);
          got = rx_got_q.pop_front();
          assert (got[7:0] == a[7:0]) else report_mismatch("rx_data_o", a[7:0], got[7:0]);
          assert (got[8] == b[0]) else report_mismatch("rx_frame_err_o", b[0], got[8]);
        end
        "O": begin
          assert (rx_overrun == a[0]) else report_mismatch("rx_overrun_o", a[0], rx_overrun);
        end
        default: report_problem("Unknown command in the trace file");
      endcase
    end
    wait_tx_done();
    repeat (2 * BIT_CYC) @(posedge clk_i);
    assert (rx_got_q.size() == 0) else report_problem("The receiver produced extra bytes");
    if (errors == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1);
    end
  end

endmodule

// File: tests/uart_trace.txt
# one command per line, hex arguments: L byte | B byte stop | H count | T count | G ticks
# E byte err (expected rx output) | O val (expected overrun flag)
L 55
L a3
E 55 0
E a3 0
B 3c 0
B 96 1
E 3c 1
E 96 0
G 5
O 0
H a
O 1
E 10 0
E 11 0
E 12 0
E 13 0
E 14 0
E 15 0
E 16 0
E 17 0
T c
L 0f
E 0f 0
O 1

// File: uart.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_rx_if.sv
rtl/uart_fifo.sv
rtl/uart_baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_top.sv
tests/uart_sva.sv
tests/uart_tb.sv
